//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef enum logic [3:0] {
		OP_ADD  = 4'b0000,
		OP_SUB  = 4'b0001,
		OP_ADDI = 4'b0010,
		OP_SLL  = 4'b0100,
		OP_SRA  = 4'b0101,
		OP_BR   = 4'b1100,
		OP_HLT  = 4'b1111
	} opcode_e;	// Unlisted codes run as no-ops

	typedef enum logic [2:0] {
		COND_NEQ    = 3'b000,
		COND_EQ     = 3'b001,
		COND_GT     = 3'b010,
		COND_LT     = 3'b011,
		COND_GEQ    = 3'b100,
		COND_LEQ    = 3'b101,
		COND_OVFL   = 3'b110,
		COND_UNCOND = 3'b111
	} cond_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_SHL = 3'd2,
		ALU_SHR = 3'd3
	} alu_op_e;

	typedef struct packed {
		opcode_e    opcode;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;	// Imm4 for ADDI, shift amount for SLL/SRA
	} r_fmt_t;

	typedef struct packed {
		opcode_e    opcode;
		cond_e      cond;
		logic [8:0] imm;	// Signed word offset
	} b_fmt_t;

	typedef union packed {
		r_fmt_t r;
		b_fmt_t b;
	} instr_u;

	typedef struct packed {
		logic n;
		logic v;
		logic z;
	} flags_t;

	typedef struct packed {
		logic        valid;
		logic [15:0] pc;
		instr_u      instr;
	} if_id_t;

	typedef struct packed {
		logic        valid;
		logic [15:0] pc;
		opcode_e     op;
		logic [3:0]  rd;
		logic [3:0]  rs;
		logic [3:0]  rt;
		cond_e       cond;
		logic [8:0]  imm9;
	} id_ex_t;

	typedef struct packed {
		logic [15:0] pc;
		logic        wen;
		logic [3:0]  rd;
		logic [15:0] result;
	} retire_t;

endpackage

`default_nettype wire

//--- verilog/barrel_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter (
	input  wire logic [15:0] data,
	input  wire logic [3:0]  amount,
	input  wire logic        arith,	// 0 SLL, 1 SRA
	output logic      [15:0] result
);

	logic [15:0] stage [5];

	assign stage[0] = data;

	for (genvar i = 0; i < 4; i++) begin : g_level
		localparam int S = 1 << i;
		logic [15:0] left, right;

		assign left  = {stage[i][15-S:0], {S{1'b0}}};
		assign right = {{S{stage[i][15]}}, stage[i][15:S]};	// Sign fill

		always_comb begin
			if (!amount[i])
				stage[i+1] = stage[i];
			else if (arith)
				stage[i+1] = right;
			else
				stage[i+1] = left;
		end
	end

	assign result = stage[4];

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
	input  wire alu_op_e     op,
	input  wire logic        imm_sel,
	input  wire logic [15:0] a,
	input  wire logic [15:0] b,
	input  wire logic [3:0]  imm4,
	output logic      [15:0] result,
	output flags_t           flags
);

	logic [15:0] imm_ext;
	logic [15:0] operand;
	logic [15:0] operand_eff;	// Inverted for SUB
	logic        sub;
	logic        shift;
	logic [15:0] sum;
	logic [15:0] shifted;
	logic        add_ovfl;

	assign imm_ext     = {{12{imm4[3]}}, imm4};
	assign operand     = imm_sel ? imm_ext : b;
	assign sub         = (op == ALU_SUB);
	assign shift       = (op == ALU_SHL) | (op == ALU_SHR);
	assign operand_eff = sub ? ~operand : operand;
	assign sum         = a + operand_eff + {15'd0, sub};

	// Same-sign operands giving a result of the other sign
	assign add_ovfl = (a[15] == operand_eff[15]) & (sum[15] != a[15]);

	barrel_shifter u_shifter (
		.data   (a),
		.amount (imm4),
		.arith  (op == ALU_SHR),
		.result (shifted)
	);

	assign result  = shift ? shifted : sum;
	assign flags.n = result[15];
	assign flags.v = shift ? 1'b0 : add_ovfl;
	assign flags.z = (result == 16'h0000);

endmodule

`default_nettype wire

//--- verilog/pc_control.sv
`timescale 1ns/1ps
`default_nettype none

module pc_control import cpu_pkg::*; (
	input  wire cond_e       cond,
	input  wire logic [8:0]  imm,
	input  wire flags_t      flags,
	input  wire logic [15:0] pc,
	output logic             taken,
	output logic      [15:0] next_pc
);

	logic [15:0] pc_plus_2;
	logic [15:0] offset;
	logic [15:0] target;

	always_comb begin
		case (cond)
			COND_NEQ:    taken = ~flags.z;
			COND_EQ:     taken = flags.z;
			COND_GT:     taken = ~flags.z & ~flags.n;
			COND_LT:     taken = flags.n;
			COND_GEQ:    taken = flags.z | ~flags.n;
			COND_LEQ:    taken = flags.z | flags.n;
			COND_OVFL:   taken = flags.v;
			COND_UNCOND: taken = 1'b1;
			default:     taken = 1'b0;
		endcase
	end

	assign pc_plus_2 = pc + 16'd2;
	assign offset    = {{6{imm[8]}}, imm, 1'b0};	// Words to bytes
	assign target    = pc_plus_2 + offset;
	assign next_pc   = taken ? target : pc_plus_2;

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_pkg::*; #(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic        redirect,
	input  wire logic [15:0] redirect_pc,
	input  wire logic        halt_req,
	output logic      [15:0] imem_addr,
	input  wire instr_u      imem_data,
	output if_id_t           if_id
);

	logic [15:0] pc;
	logic        stopped;	// Set by HLT, cleared only by reset

	assign imem_addr = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc      <= RESET_PC;
			stopped <= 1'b0;
			if_id   <= '0;
		end else if (halt_req) begin
			stopped     <= 1'b1;
			if_id.valid <= 1'b0;	// PC frozen from here on
		end else if (redirect) begin
			pc          <= redirect_pc;
			if_id.valid <= 1'b0;	// Drop wrong-path word
		end else if (!stopped) begin
			pc          <= pc + 16'd2;
			if_id.valid <= 1'b1;
			if_id.pc    <= pc;
			if_id.instr <= imem_data;
		end else begin
			if_id.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
	input  wire logic   clk,
	input  wire logic   rst_n,
	input  wire logic   flush,
	input  wire if_id_t if_id,
	output id_ex_t      id_ex
);

	r_fmt_t  r_view;
	b_fmt_t  b_view;
	opcode_e opcode;

	assign opcode = if_id.instr.r.opcode;	// Same position in both forms
	assign r_view = if_id.instr.r;
	assign b_view = if_id.instr.b;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else begin
			id_ex.valid <= if_id.valid & ~flush;
			id_ex.pc    <= if_id.pc;
			id_ex.op    <= opcode;
			id_ex.rd    <= r_view.rd;
			id_ex.rs    <= r_view.rs;
			id_ex.rt    <= r_view.rt;
			// Branch view overlaps rd/rs/rt
			id_ex.cond  <= b_view.cond;
			id_ex.imm9  <= b_view.imm;
		end
	end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
	input  wire logic   clk,
	input  wire logic   rst_n,
	input  wire id_ex_t id_ex,
	output logic        redirect,
	output logic [15:0] redirect_pc,
	output logic        halt_req,
	output logic        retire_valid,
	output retire_t     retire,
	output logic        halted
);

	logic [15:0] regs [16];
	flags_t      flags;
	logic [15:0] rs_val, rt_val;
	alu_op_e     alu_op;
	logic        imm_sel;
	logic        wr_op;		// Opcode writes rd and flags
	logic        wen;
	logic [15:0] alu_result;
	flags_t      alu_flags;
	logic        taken;

	assign rs_val = regs[id_ex.rs];
	assign rt_val = regs[id_ex.rt];

	always_comb begin
		alu_op  = ALU_ADD;
		imm_sel = 1'b0;
		wr_op   = 1'b1;
		case (id_ex.op)
			OP_ADD:  alu_op = ALU_ADD;
			OP_SUB:  alu_op = ALU_SUB;
			OP_ADDI: imm_sel = 1'b1;
			OP_SLL:  alu_op = ALU_SHL;
			OP_SRA:  alu_op = ALU_SHR;
			default: wr_op = 1'b0;	// BR, HLT and no-ops
		endcase
	end

	assign wen = id_ex.valid & wr_op;

	alu u_alu (
		.op      (alu_op),
		.imm_sel (imm_sel),
		.a       (rs_val),
		.b       (rt_val),
		.imm4    (id_ex.rt),
		.result  (alu_result),
		.flags   (alu_flags)
	);

	pc_control u_pc_control (
		.cond    (id_ex.cond),
		.imm     (id_ex.imm9),
		.flags   (flags),
		.pc      (id_ex.pc),
		.taken   (taken),
		.next_pc (redirect_pc)
	);

	assign redirect = id_ex.valid & (id_ex.op == OP_BR) & taken;
	assign halt_req = id_ex.valid & (id_ex.op == OP_HLT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
			flags        <= '0;
			retire_valid <= 1'b0;
			halted       <= 1'b0;
		end else begin
			if (wen) begin
				regs[id_ex.rd] <= alu_result;
				flags          <= alu_flags;
			end
			retire_valid <= id_ex.valid & ~halt_req;
			if (halt_req)
				halted <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		retire.pc     <= id_ex.pc;
		retire.wen    <= wen;
		retire.rd     <= id_ex.rd;
		retire.result <= wen ? alu_result : 16'h0000;
	end

endmodule

`default_nettype wire

//--- verilog/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; #(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input  wire logic        clk,
	input  wire logic        rst_n,
	output logic      [15:0] imem_addr,
	input  wire instr_u      imem_data,
	output logic             retire_valid,
	output retire_t          retire,
	output logic             halted
);

	if_id_t      if_id;
	id_ex_t      id_ex;
	logic        redirect;
	logic [15:0] redirect_pc;
	logic        halt_req;

	fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
		.clk         (clk),
		.rst_n       (rst_n),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.halt_req    (halt_req),
		.imem_addr   (imem_addr),
		.imem_data   (imem_data),
		.if_id       (if_id)
	);

	decode_stage u_decode (
		.clk   (clk),
		.rst_n (rst_n),
		.flush (redirect | halt_req),	// Kill the word behind a branch or HLT
		.if_id (if_id),
		.id_ex (id_ex)
	);

	execute_stage u_execute (
		.clk          (clk),
		.rst_n        (rst_n),
		.id_ex        (id_ex),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.halt_req     (halt_req),
		.retire_valid (retire_valid),
		.retire       (retire),
		.halted       (halted)
	);

endmodule

`default_nettype wire

//--- tb/tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core import cpu_pkg::*; ();

	localparam logic [15:0] RESET_PC = 16'h0000;

	logic        clk = 1'b0;
	logic        rst_n;
	logic [15:0] imem_addr;
	instr_u      imem_data;
	logic        retire_valid;
	retire_t     retire;
	logic        halted;

	logic [15:0] imem [256];
	int          load_idx;
	retire_t     exp_q [$];
	int          ret_idx;
	int          checks;
	int          mismatch_errors;
	int          other_errors;
	logic        timed_out;

	always #4 clk = ~clk;

	// Words past the array read as HLT
	assign imem_data = (imem_addr[15:9] == 7'd0) ? imem[imem_addr[8:1]] :
		{4'hF, imem_addr[12:1]};

	cpu_core #(.RESET_PC(RESET_PC)) dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.imem_addr    (imem_addr),
		.imem_data    (imem_data),
		.retire_valid (retire_valid),
		.retire       (retire),
		.halted       (halted)
	);

	task automatic report_mismatch(string name, logic [15:0] got, logic [15:0] exp);
		mismatch_errors++;
		$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
	endtask

	task automatic report_other(string msg);
		other_errors++;
		$display("Error at t=%0t: %s", $time, msg);
	endtask

	function automatic logic [15:0] encode_reg(logic [3:0] op, logic [3:0] rd,
		logic [3:0] rs, logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [15:0] encode_branch(logic [2:0] cond, int off);
		return {4'hC, cond, off[8:0]};
	endfunction

	function automatic logic [15:0] read_imem(logic [15:0] addr);
		if (addr[15:9] != 7'd0)
			return {4'hF, addr[12:1]};
		return imem[addr[8:1]];
	endfunction

	function automatic logic cond_holds(logic [2:0] cond, logic n, logic v, logic z);
		case (cond)
			3'd0: return !z;
			3'd1: return z;
			3'd2: return !z && !n;
			3'd3: return n;
			3'd4: return z || !n;
			3'd5: return z || n;
			3'd6: return v;
			default: return 1'b1;
		endcase
	endfunction

	task automatic clear_imem();
		for (int i = 0; i < 256; i++)
			imem[i] = {4'hF, 4'h0, 8'(i)};	// HLT with index in low bits
		load_idx = 0;
	endtask

	task automatic emit(logic [15:0] word);
		imem[load_idx] = word;
		load_idx++;
	endtask

	// Runs the loaded program and builds the expected retire list
	task automatic run_model();
		logic [15:0] regs [16];
		logic [15:0] pc, word, a, b, res, next_pc;
		logic        n, v, z, wr;
		int          steps;
		retire_t     rec;
		exp_q.delete();
		foreach (regs[i])
			regs[i] = '0;
		{n, v, z} = 3'b000;
		pc = RESET_PC;
		steps = 0;
		word = read_imem(pc);
		while (word[15:12] != 4'hF && steps < 1000) begin
			a = regs[word[7:4]];
			b = regs[word[3:0]];
			res = '0;
			wr = 1'b1;
			next_pc = pc + 16'd2;
			case (word[15:12])
				4'h0: begin
					res = a + b;
					v = (a[15] == b[15]) && (res[15] != a[15]);
				end
				4'h1: begin
					res = a - b;
					v = (a[15] != b[15]) && (res[15] != a[15]);
				end
				4'h2: begin
					b = {{12{word[3]}}, word[3:0]};
					res = a + b;
					v = (a[15] == b[15]) && (res[15] != a[15]);
				end
				4'h4: begin
					res = a << word[3:0];
					v = 1'b0;
				end
				4'h5: begin
					res = $signed(a) >>> word[3:0];
					v = 1'b0;
				end
				4'hC: begin
					wr = 1'b0;
					if (cond_holds(word[11:9], n, v, z))
						next_pc = pc + 16'd2 + {{6{word[8]}}, word[8:0], 1'b0};
				end
				default: wr = 1'b0;
			endcase
			if (wr) begin
				regs[word[11:8]] = res;
				n = res[15];
				z = (res == 16'h0000);
			end
			rec.pc = pc;
			rec.wen = wr;
			rec.rd = word[11:8];
			rec.result = res;
			exp_q.push_back(rec);
			pc = next_pc;
			word = read_imem(pc);
			steps++;
		end
		if (steps >= 1000)
			report_other("reference model did not reach HLT");
	endtask

	task automatic load_directed();
		clear_imem();
		emit(encode_reg(OP_ADDI, 4'd1, 4'd0, 4'd1));
		emit(encode_reg(OP_ADDI, 4'd2, 4'd0, 4'hF));	// -1
		emit(encode_reg(OP_ADDI, 4'd3, 4'd0, 4'd7));
		emit(encode_branch(COND_NEQ, 1));
		emit(encode_reg(OP_ADDI, 4'd4, 4'd4, 4'd1));	// Wrong path
		emit(encode_reg(OP_SUB, 4'd5, 4'd1, 4'd1));	// Zero result
		emit(encode_branch(COND_NEQ, 1));
		emit(encode_branch(COND_EQ, 1));
		emit(encode_reg(OP_ADDI, 4'd4, 4'd4, 4'd1));
		emit(encode_reg(OP_ADD, 4'd6, 4'd1, 4'd3));
		emit(encode_branch(COND_EQ, 1));
		emit(encode_branch(COND_GT, 1));
		emit(encode_reg(OP_ADDI, 4'd4, 4'd4, 4'd1));
		emit(encode_branch(COND_LT, 1));
		emit(encode_branch(COND_LEQ, 1));
		emit(encode_branch(COND_GEQ, 1));
		emit(encode_reg(OP_ADDI, 4'd4, 4'd4, 4'd1));
		emit(encode_reg(OP_SLL, 4'd7, 4'd2, 4'd4));	// Negative
		emit(encode_branch(COND_GT, 1));
		emit(encode_branch(COND_GEQ, 1));
		emit(encode_branch(COND_LT, 1));
		emit(encode_reg(OP_ADDI, 4'd4, 4'd4, 4'd1));
		emit(encode_branch(COND_LEQ, 1));
		emit(encode_reg(OP_ADDI, 4'd4, 4'd4, 4'd1));
		emit(encode_reg(OP_SLL, 4'd9, 4'd3, 4'd12));
		emit(encode_branch(COND_OVFL, 1));
		emit(encode_reg(OP_ADD, 4'd10, 4'd9, 4'd9));	// Overflow
		emit(encode_branch(COND_OVFL, 1));
		emit(encode_reg(OP_ADDI, 4'd4, 4'd4, 4'd1));
		emit(encode_reg(OP_SRA, 4'd11, 4'd10, 4'd3));
		emit(encode_reg(OP_SLL, 4'd13, 4'd1, 4'd15));
		emit(encode_reg(OP_SUB, 4'd12, 4'd13, 4'd1));	// Overflow on SUB
		emit(encode_reg(4'h3, 4'd0, 4'd0, 4'd0));	// No-op
		emit(encode_reg(OP_ADDI, 4'd14, 4'd0, 4'd3));
		emit(encode_reg(OP_ADDI, 4'd15, 4'd15, 4'd2));	// Loop body
		emit(encode_reg(OP_ADDI, 4'd14, 4'd14, 4'hF));
		emit(encode_branch(COND_NEQ, -3));
		emit(encode_branch(COND_UNCOND, 2));
		emit(encode_reg(OP_ADDI, 4'd4, 4'd4, 4'd1));
		emit(encode_reg(OP_ADDI, 4'd4, 4'd4, 4'd1));
		emit(encode_reg(OP_ADD, 4'd4, 4'd4, 4'd0));	// Stays zero unless a wrong path wrote
		emit(encode_reg(OP_HLT, 4'd0, 4'd0, 4'd0));
	endtask

	task automatic load_random(int len);
		logic [3:0] rd, rs, rt;
		int         kind;
		clear_imem();
		for (int i = 0; i < len; i++) begin
			rd = 4'($urandom_range(0, 15));
			rs = 4'($urandom_range(0, 15));
			rt = 4'($urandom_range(0, 15));
			kind = (i < 4) ? 3 : $urandom_range(0, 9);	// Seed registers first
			case (kind)
				0, 1: emit(encode_reg(OP_ADD, rd, rs, rt));
				2, 9: emit(encode_reg(OP_SUB, rd, rs, rt));
				3: emit(encode_reg(OP_ADDI, rd, rs, rt));
				4: emit(encode_reg(OP_SLL, rd, rs, rt));
				5: emit(encode_reg(OP_SRA, rd, rs, rt));
				6, 7: emit(encode_branch(3'($urandom_range(0, 7)), $urandom_range(0, 3)));
				default: emit(encode_reg(4'hA, rd, rs, rt));
			endcase
		end
		emit(encode_reg(OP_HLT, 4'd0, 4'd0, 4'd0));
	endtask

	task automatic run_program();
		int cycles;
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (16) @(posedge clk);
		run_model();
		ret_idx = 0;
		rst_n <= 1'b1;
		@(negedge clk);
		assert (imem_addr === RESET_PC) else report_mismatch("imem_addr", imem_addr, RESET_PC);
		assert (halted === 1'b0) else report_mismatch("halted", halted, 0);
		assert (retire_valid === 1'b0) else report_mismatch("retire_valid", retire_valid, 0);
		cycles = 0;
		while (!halted && cycles < 2000) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			timed_out = 1'b1;
			report_other("halted did not rise within 2000 cycles");
		end else begin
			repeat (4) @(negedge clk);
			assert (ret_idx == exp_q.size())
				else report_mismatch("retire_count", 16'(ret_idx), 16'(exp_q.size()));
		end
	endtask

	always @(negedge clk) begin
		if (!rst_n) begin
			assert (retire_valid === 1'b0) else report_mismatch("retire_valid", retire_valid, 0);
			assert (halted === 1'b0) else report_mismatch("halted", halted, 0);
			assert (imem_addr === RESET_PC) else report_mismatch("imem_addr", imem_addr, RESET_PC);
		end else if (retire_valid) begin
			assert (!halted) else report_other("retire strobe after halt");
			assert (ret_idx < exp_q.size()) else report_other("more retires than expected");
			if (ret_idx < exp_q.size()) begin
				checks++;
				assert (retire.pc === exp_q[ret_idx].pc)
					else report_mismatch("retire.pc", retire.pc, exp_q[ret_idx].pc);
				assert (retire.wen === exp_q[ret_idx].wen)
					else report_mismatch("retire.wen", retire.wen, exp_q[ret_idx].wen);
				if (exp_q[ret_idx].wen) begin
					assert (retire.rd === exp_q[ret_idx].rd)
						else report_mismatch("retire.rd", retire.rd, exp_q[ret_idx].rd);
					assert (retire.result === exp_q[ret_idx].result)
						else report_mismatch("retire.result", retire.result, exp_q[ret_idx].result);
				end
				ret_idx++;
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		checks = 0;
		mismatch_errors = 0;
		other_errors = 0;
		timed_out = 1'b0;
		ret_idx = 0;
		void'($urandom(32'hbc886de0));
		load_directed();
		run_program();
		for (int p = 0; p < 8 && !timed_out; p++) begin
			load_random($urandom_range(16, 40));
			run_program();
		end
		$display("Retires checked: %0d, value errors: %0d, other errors: %0d",
			checks, mismatch_errors, other_errors);
		if (mismatch_errors + other_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
verilog/cpu_pkg.sv
verilog/barrel_shifter.sv
verilog/alu.sv
verilog/pc_control.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/cpu_core.sv
tb/tb_cpu_core.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - verilog/cpu_pkg.sv
  - verilog/barrel_shifter.sv
  - verilog/alu.sv
  - verilog/pc_control.sv
  - verilog/fetch_stage.sv
  - verilog/decode_stage.sv
  - verilog/execute_stage.sv
  - verilog/cpu_core.sv
  - target: test
    files:
      - tb/tb_cpu_core.sv
